/* cpu.f */
verilog/datapathPkg.sv
verilog/isaPkg.sv
verilog/alu.sv
verilog/microSequencer.sv
verilog/busDatapath.sv
verilog/memory.sv
verilog/cpu.sv
tb/cpu_properties.sv
tb/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f cpu.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import isaPkg::*;

    localparam int RESET_CYCLES   = 16;

    logic        clk;
    logic        rstN;
    logic        loadEn;
    logic [7:0]  loadAddr;
    logic [15:0] loadData;
    logic [15:0] inData;
    logic [15:0] outData;
    logic        outValid;
    logic        halted;

    logic [15:0] lfsrState;
    logic [15:0] refMem [256];
    logic [15:0] expQ[$];
    logic [15:0] dataQ[$];
    int          addrQ[$];
    int          storeQ[$];
    int          progAddr, outIdx, testErrors, passCount, failCount;
    int          cycleCount, cycleLimit, runCycles, maxExpected;
    opcodeT      aluOps [3] = '{ADD, SUB, AND};

    cpu i_dut (
        .clk, .rstN, .inData, .loadEn, .loadAddr, .loadData, .outData, .outValid, .halted
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] randomBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic putWord(input int a, input logic [15:0] d);
        addrQ.push_back(a);
        dataQ.push_back(d);
    endtask

    task automatic emitInstr(input opcodeT op, input int arg);
        putWord(progAddr, {op, arg[11:0]});
        progAddr++;
    endtask

    // Behavioral ISA model that fills expQ and storeQ and returns the cycles up to halt
    function automatic int refRun(input logic [15:0] inValue);
        logic [15:0] x, y, ir;
        logic [16:0] s;
        logic        c, z, l, done;
        int          pc, cycles;
        opcodeT      op;
        x = '0;
        y = '0;
        s = '0;
        {c, z, l, done} = 4'b0000;
        pc = 0;
        cycles = 0;
        expQ.delete();
        storeQ.delete();
        for (int i = 0; i < 256; i++) refMem[i] = '0;
        foreach (addrQ[i]) refMem[addrQ[i]] = dataQ[i];
        while (!done) begin
            ir = refMem[pc];
            pc = (pc + 1) % 256;
            op = opcodeT'(ir[15:12]);
            cycles += (op inside {LDX, LDY, STX}) ? 4 : 3;
            case (op)
                LDI:  x = {4'h0, ir[11:0]};
                LDX:  x = refMem[ir[7:0]];
                LDY:  y = refMem[ir[7:0]];
                STX: begin
                    refMem[ir[7:0]] = x;
                    storeQ.push_back(ir[7:0]);
                end
                ADD:  s = {1'b0, x} + {1'b0, y};
                SUB:  s = {x >= y, x - y};  // Carry set when no borrow
                AND:  s = {1'b0, x & y};
                NOTX: s = {1'b0, ~x};
                OUT:  expQ.push_back(x);
                INP:  x = inValue;
                JMP:  pc = ir[7:0];
                JZ:   if (z) pc = ir[7:0];
                JC:   if (c) pc = ir[7:0];
                JLT:  if (l) pc = ir[7:0];
                HLT:  done = 1'b1;
                default: ;
            endcase
            if (op inside {ADD, SUB, AND, NOTX}) begin
                x = s[15:0];
                c = s[16];
                z = (s[15:0] == 16'h0000);
                l = s[15];
            end
        end
        return cycles;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            testErrors++;
        end
    endtask

    always @(negedge clk) begin
        if (rstN && outValid) begin
            if (outIdx < expQ.size()) begin
                checkValue(outData, expQ[outIdx], $sformatf("output word %0d", outIdx));
            end else begin
                $display("Output %h at %0t ns has no expected word to match", outData, $time);
                testErrors++;
            end
            outIdx++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (rstN) runCycles++;
        if (cycleCount > cycleLimit) begin
            $display("Stopped after %0d cycles because the CPU never halted", cycleCount);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic runProgram(input string name);
        int expCycles;
        expCycles = refRun(inData);
        if (expCycles > maxExpected) maxExpected = expCycles;
        cycleLimit = 2 * maxExpected + RESET_CYCLES;
        {testErrors, outIdx, cycleCount, runCycles} = '0;
        rstN = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin  // Program goes in while reset is held
            loadEn = (i < addrQ.size());
            if (loadEn) begin
                loadAddr = addrQ[i][7:0];
                loadData = dataQ[i];
            end
            @(negedge clk);
        end
        loadEn = 1'b0;
        rstN = 1'b1;
        while (!halted) @(negedge clk);
        checkValue(runCycles, expCycles, "cycles to halt");
        repeat (4) begin
            @(negedge clk);
            checkValue(halted, 1, "halted after halt");
        end
        checkValue(outIdx, expQ.size(), "number of output words");
        foreach (storeQ[i])
            checkValue(i_dut.i_memory.mem[storeQ[i]], refMem[storeQ[i]], "stored word");
        if (testErrors == 0) begin
            passCount++;
            $display("Test %s: ok, %0d words out, halt at %0d", name, expQ.size(), runCycles);
        end else begin
            failCount++;
            $display("Test %s: %0d errors", name, testErrors);
        end
        addrQ.delete();
        dataQ.delete();
        progAddr = 0;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inData = '0;
        lfsrState = 16'd3306;
        {progAddr, passCount, failCount, maxExpected, cycleCount, runCycles} = '0;
        cycleLimit = 4 * RESET_CYCLES;
        @(negedge clk);

        for (int i = 0; i < 7; i++) begin
            emitInstr(LDI, randomBits(12));
            emitInstr(OUT, 0);
        end
        emitInstr(HLT, 0);
        runProgram("immediate and output");

        putWord(8'h40, randomBits(16));
        putWord(8'h41, randomBits(16));
        emitInstr(LDY, 8'h41);
        foreach (aluOps[i]) begin
            emitInstr(LDX, 8'h40);
            emitInstr(aluOps[i], 0);
            emitInstr(OUT, 0);
        end
        emitInstr(NOTX, 0);
        emitInstr(OUT, 0);
        emitInstr(HLT, 0);
        runProgram("arithmetic and logic");

        putWord(8'h90, randomBits(16));  // Old contents that the store must replace
        emitInstr(LDI, randomBits(12));
        emitInstr(STX, 8'h90);
        emitInstr(LDY, 8'h90);
        emitInstr(ADD, 0);
        emitInstr(OUT, 0);
        emitInstr(HLT, 0);
        runProgram("store and reload");

        putWord(8'h80, randomBits(16));
        emitInstr(LDX, 8'h80);
        emitInstr(LDY, 8'h80);
        emitInstr(SUB, 0);
        emitInstr(JZ, 5);
        emitInstr(OUT, 0);
        emitInstr(JC, 7);
        emitInstr(OUT, 0);
        emitInstr(JLT, 9);
        emitInstr(OUT, 0);
        emitInstr(NOTX, 0);  // Clears carry and sets less for the second pair
        emitInstr(JC, 12);
        emitInstr(OUT, 0);
        emitInstr(JLT, 14);
        emitInstr(OUT, 0);
        emitInstr(HLT, 0);
        runProgram("conditional jumps");

        inData = randomBits(16);
        emitInstr(INP, 0);
        emitInstr(OUT, 0);
        emitInstr(HLT, 0);
        runProgram("input port and halt");

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
    input wire logic clk,
    input wire logic rstN,
    input wire logic outValid,
    input wire logic loadPc,
    input wire logic incPc,
    input wire logic loadAr,
    input wire logic loadIr,
    input wire logic loadX,
    input wire logic loadY
);

    outPulse: assert property (@(posedge clk) disable iff (!rstN) outValid |=> !outValid)
        else $error("outValid high on two consecutive cycles");

    pcUpdate: assert property (@(posedge clk) disable iff (!rstN) !(loadPc && incPc))
        else $error("loadPc and incPc high together");

    resetQuiet: assert property (@(posedge clk) !rstN |->
            !(loadAr || loadIr || loadX || loadY || loadPc || incPc))
        else $error("register load enable high during reset");

endmodule

bind busDatapath cpu_properties i_properties (
    .clk, .rstN, .outValid, .loadPc, .incPc, .loadAr, .loadIr, .loadX, .loadY
);

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic [datapathPkg::DATA_W-1:0]     xVal,
    input  wire logic [datapathPkg::DATA_W-1:0]     yVal,
    input  wire logic [datapathPkg::ALU_CTRL_W-1:0] aluCtrl,
    input  wire logic                              carryIn,
    input  wire logic                              flagUpdate,
    output logic      [datapathPkg::DATA_W-1:0]     aluResult,
    output logic                                   carryFlag,
    output logic                                   zeroFlag,
    output logic                                   lessFlag
);
    import datapathPkg::*;

    logic [DATA_W-1:0] xZero, xCond, yZero, yCond, fOut;
    logic [DATA_W:0]   sum;

    always_comb begin
        xZero = aluCtrl[ALU_EX] ? '0 : xVal;
        xCond = aluCtrl[ALU_NX] ? ~xZero : xZero;
        yZero = aluCtrl[ALU_EY] ? '0 : yVal;
        yCond = aluCtrl[ALU_NY] ? ~yZero : yZero;
        sum   = {1'b0, xCond} + {1'b0, yCond} + {{DATA_W{1'b0}}, carryIn};
        fOut  = aluCtrl[ALU_F] ? sum[DATA_W-1:0] : (xCond & yCond);
        aluResult = aluCtrl[ALU_NO] ? ~fOut : fOut;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
            lessFlag  <= 1'b0;
        end else if (flagUpdate) begin
            carryFlag <= aluCtrl[ALU_F] & sum[DATA_W];  // No carry out of the and path
            zeroFlag  <= (aluResult == '0);
            lessFlag  <= aluResult[DATA_W-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/busDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module busDatapath (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire datapathPkg::busSrcT           busSrc,
    input  wire logic                          loadAr,
    input  wire logic                          loadIr,
    input  wire logic                          loadX,
    input  wire logic                          loadY,
    input  wire logic                          incPc,
    input  wire logic                          loadPc,
    input  wire logic                          outStrobe,
    input  wire logic [datapathPkg::DATA_W-1:0] aluResult,
    input  wire logic [datapathPkg::DATA_W-1:0] readData,
    input  wire logic [datapathPkg::DATA_W-1:0] inData,
    output isaPkg::opcodeT                     opcode,
    output logic      [datapathPkg::DATA_W-1:0] xVal,
    output logic      [datapathPkg::DATA_W-1:0] yVal,
    output logic      [datapathPkg::ADDR_W-1:0] addr,
    output logic      [datapathPkg::DATA_W-1:0] outData,
    output logic                               outValid
);
    import isaPkg::*;
    import datapathPkg::*;

    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] ir;
    logic [DATA_W-1:0] bus;

    assign opcode = opcodeT'(ir[DATA_W-1 -: OPCODE_W]);

    // Stands in for the shared tri-state bus
    always_comb begin
        case (busSrc)
            PC:      bus = {{(DATA_W-ADDR_W){1'b0}}, pc};
            IR_LOW:  bus = {{(DATA_W-OPERAND_W){1'b0}}, ir[OPERAND_W-1:0]};
            MEM:     bus = readData;
            ALU:     bus = aluResult;
            INPORT:  bus = inData;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= '0;
            ir       <= '0;
            outValid <= 1'b0;
        end else begin
            if (loadPc) pc <= bus[ADDR_W-1:0];  // Jump target truncates to memory range
            else if (incPc) pc <= pc + 1'b1;
            if (loadIr) ir <= bus;
            outValid <= outStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (loadX) xVal <= bus;
        if (loadY) yVal <= bus;
        if (loadAr) addr <= bus[ADDR_W-1:0];
        if (outStrobe) outData <= xVal;
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [datapathPkg::DATA_W-1:0] inData,
    input  wire logic                          loadEn,
    input  wire logic [datapathPkg::ADDR_W-1:0] loadAddr,
    input  wire logic [datapathPkg::DATA_W-1:0] loadData,
    output logic      [datapathPkg::DATA_W-1:0] outData,
    output logic                               outValid,
    output logic                               halted
);
    import isaPkg::*;
    import datapathPkg::*;

    busSrcT                busSrc;
    opcodeT                opcode;
    logic                  loadAr, loadIr, loadX, loadY;
    logic                  memWrite, incPc, loadPc, outStrobe;
    logic [ALU_CTRL_W-1:0] aluCtrl;
    logic                  carryIn, flagUpdate;
    logic                  carryFlag, zeroFlag, lessFlag;
    logic [DATA_W-1:0]     xVal, yVal, aluResult, readData;
    logic [ADDR_W-1:0]     addr;

    microSequencer i_sequencer (
        .clk, .rstN, .opcode, .carryFlag, .zeroFlag, .lessFlag,
        .busSrc, .loadAr, .loadIr, .loadX, .loadY, .memWrite, .incPc, .loadPc,
        .outStrobe, .aluCtrl, .carryIn, .flagUpdate, .halted
    );

    busDatapath i_datapath (
        .clk, .rstN, .busSrc, .loadAr, .loadIr, .loadX, .loadY, .incPc, .loadPc,
        .outStrobe, .aluResult, .readData, .inData,
        .opcode, .xVal, .yVal, .addr, .outData, .outValid
    );

    alu i_alu (
        .clk, .rstN, .xVal, .yVal, .aluCtrl, .carryIn, .flagUpdate,
        .aluResult, .carryFlag, .zeroFlag, .lessFlag
    );

    memory i_memory (
        .clk, .addr, .writeData(xVal), .memWrite, .loadEn, .loadAddr, .loadData, .readData
    );

endmodule

`default_nettype wire

/* verilog/datapathPkg.sv */
`default_nettype none

package datapathPkg;

    localparam int DATA_W    = 16;
    localparam int MEM_DEPTH = 256;
    localparam int ADDR_W    = 8;

    // Whoever drives the internal bus this cycle
    typedef enum logic [2:0] {
        NONE, PC, IR_LOW, MEM, ALU, INPORT
    } busSrcT;

    localparam int ALU_CTRL_W = 6;

    localparam int ALU_EX = 5;  // Zero X
    localparam int ALU_NX = 4;  // Invert X
    localparam int ALU_EY = 3;  // Zero Y
    localparam int ALU_NY = 2;  // Invert Y
    localparam int ALU_F  = 1;  // Add when set, otherwise and
    localparam int ALU_NO = 0;  // Invert result

endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int OPCODE_W  = 4;
    localparam int OPERAND_W = 12;  // Low instruction field, immediate or address

    typedef enum logic [OPCODE_W-1:0] {
        NOP, LDI, LDX, LDY,
        STX, ADD, SUB, AND,
        NOTX, OUT, INP, JMP,
        JZ, JC, JLT, HLT
    } opcodeT;

    typedef enum logic [2:0] {
        T0, T1, T2, T3, T4
    } stepT;

    // ALU control words, bit order EX NX EY NY F NO
    localparam logic [datapathPkg::ALU_CTRL_W-1:0] ALU_ADD  = 6'b000010;
    localparam logic [datapathPkg::ALU_CTRL_W-1:0] ALU_SUB  = 6'b000110;  // Needs carryIn set
    localparam logic [datapathPkg::ALU_CTRL_W-1:0] ALU_AND  = 6'b000000;

    // Y forced to all ones so the AND passes the inverted X through
    localparam logic [datapathPkg::ALU_CTRL_W-1:0] ALU_NOTX = 6'b011100;

endpackage

`default_nettype wire

/* verilog/memory.sv */
`timescale 1ns/1ps
`default_nettype none

module memory (
    input  wire logic                          clk,
    input  wire logic [datapathPkg::ADDR_W-1:0] addr,
    input  wire logic [datapathPkg::DATA_W-1:0] writeData,
    input  wire logic                          memWrite,
    input  wire logic                          loadEn,
    input  wire logic [datapathPkg::ADDR_W-1:0] loadAddr,
    input  wire logic [datapathPkg::DATA_W-1:0] loadData,
    output logic      [datapathPkg::DATA_W-1:0] readData
);
    import datapathPkg::*;

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    assign readData = mem[addr];

    // The load port owns the array while the program is written in
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (memWrite) begin
            mem[addr] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* verilog/microSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module microSequencer (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire isaPkg::opcodeT                    opcode,
    input  wire logic                              carryFlag,
    input  wire logic                              zeroFlag,
    input  wire logic                              lessFlag,
    output datapathPkg::busSrcT                    busSrc,
    output logic                                   loadAr,
    output logic                                   loadIr,
    output logic                                   loadX,
    output logic                                   loadY,
    output logic                                   memWrite,
    output logic                                   incPc,
    output logic                                   loadPc,
    output logic                                   outStrobe,
    output logic [datapathPkg::ALU_CTRL_W-1:0]     aluCtrl,
    output logic                                   carryIn,
    output logic                                   flagUpdate,
    output logic                                   halted
);
    import isaPkg::*;
    import datapathPkg::*;

    stepT step;
    logic active;    // No control word leaves the table in reset or after halt
    logic lastStep;
    logic haltNow;

    assign active = rstN & ~halted;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            step    <= T0;
            halted  <= 1'b0;
        end else if (active) begin
            if (haltNow) halted <= 1'b1;  // Step stays frozen from here on
            else if (lastStep) step <= T0;
            else step <= stepT'(step + 3'd1);
        end
    end

    // Microcode table, one control word per opcode and step
    always_comb begin
        busSrc     = NONE;
        loadAr     = 1'b0;
        loadIr     = 1'b0;
        loadX      = 1'b0;
        loadY      = 1'b0;
        memWrite   = 1'b0;
        incPc      = 1'b0;
        loadPc     = 1'b0;
        outStrobe  = 1'b0;
        aluCtrl    = ALU_AND;
        carryIn    = 1'b0;
        flagUpdate = 1'b0;
        lastStep   = 1'b0;
        haltNow    = 1'b0;
        if (active) begin
            case (step)
                T0: begin busSrc = PC; loadAr = 1'b1; end
                T1: begin busSrc = MEM; loadIr = 1'b1; incPc = 1'b1; end
                T2: begin
                    lastStep = 1'b1;
                    case (opcode)
                        LDI:  begin busSrc = IR_LOW; loadX = 1'b1; end
                        LDX, LDY, STX: begin
                            busSrc   = IR_LOW;  // Operand address, move follows in T3
                            loadAr   = 1'b1;
                            lastStep = 1'b0;
                        end
                        ADD, SUB, AND, NOTX: begin
                            busSrc     = ALU;
                            loadX      = 1'b1;
                            flagUpdate = 1'b1;
                            carryIn    = (opcode == SUB);
                            aluCtrl    = (opcode == ADD) ? ALU_ADD :
                                         (opcode == SUB) ? ALU_SUB :
                                         (opcode == NOTX) ? ALU_NOTX : ALU_AND;
                        end
                        OUT:  outStrobe = 1'b1;
                        INP:  begin busSrc = INPORT; loadX = 1'b1; end
                        JMP, JZ, JC, JLT: begin
                            busSrc = IR_LOW;
                            loadPc = (opcode == JMP) | (opcode == JZ & zeroFlag) |
                                     (opcode == JC & carryFlag) | (opcode == JLT & lessFlag);
                        end
                        HLT:  begin haltNow = 1'b1; lastStep = 1'b0; end
                        default: ;
                    endcase
                end
                T3: begin
                    lastStep = 1'b1;
                    busSrc   = MEM;
                    loadX    = (opcode == LDX);
                    loadY    = (opcode == LDY);
                    memWrite = (opcode == STX);
                end
                default: lastStep = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire
